//--- compile.f
verilog/video_timing_pkg.sv
verilog/ppu_pkg.sv
verilog/video_timing.sv
verilog/ppu_regs.sv
verilog/layer_mix.sv
verilog/palette.sv
verilog/cps_video.sv
verif/cps_video_props.sv
verif/cps_video_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the cps_video testbench with Verilator; the log decides pass or fail
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timing --timescale 1ns/1ns --top-module cps_video_tb \
    -f compile.f || { echo "Build failed"; exit 1; }
./obj_dir/Vcps_video_tb +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "Simulation ended without a verdict"; exit 1; }
exit 0

//--- verif/cps_video_props.sv
/* Timing, raster and blanking properties bound into cps_video.
   The raster check assumes only line 5 is ever enabled as the interrupt line. */
`default_nettype none

module cps_video_props #(
    parameter int H_ACTIVE = 384,
    parameter int HS_START = 400,
    parameter int HS_LEN   = 36,
    parameter int V_TOTAL  = 262,
    parameter int V_ACTIVE = 224,
    parameter int VS_START = 236,
    parameter int VS_LEN   = 3
) (
    input logic                    clk,
    input logic                    rst,
    input video_timing_pkg::hpos_t hdump,
    input video_timing_pkg::vpos_t vdump,
    input video_timing_pkg::vpos_t vrender,
    input logic                    hb, vb, hs, vs,
    input logic                    line_start, raster,
    input logic                    lhbl_dly, lvbl_dly,
    input ppu_pkg::color_t         red, green, blue
);
    timeunit 1ns;
    timeprecision 1ns;
    import video_timing_pkg::*;

    localparam int RASTER_LINE = 5;

    int fail_count = 0;

    task automatic note_failure(input string what);
        fail_count++;
        $error("%s", what);
    endtask

    // Blanking and sync are decodes of the count they come out with
    hb_window: assert property (@(posedge clk) disable iff (rst)
        hb == (int'(hdump) >= H_ACTIVE))
        else note_failure("HB out of step with hdump");
    vb_window: assert property (@(posedge clk) disable iff (rst)
        vb == (int'(vdump) >= V_ACTIVE))
        else note_failure("VB out of step with vdump");
    hs_window: assert property (@(posedge clk) disable iff (rst)
        hs == (int'(hdump) >= HS_START && int'(hdump) < HS_START + HS_LEN))
        else note_failure("HS outside its window");
    vs_window: assert property (@(posedge clk) disable iff (rst)
        vs == (int'(vdump) >= VS_START && int'(vdump) < VS_START + VS_LEN))
        else note_failure("VS outside its window");

    line_start_at_zero: assert property (@(posedge clk) disable iff (rst)
        line_start |-> hdump == '0)
        else note_failure("line_start with hdump not zero");
    line_start_single: assert property (@(posedge clk) disable iff (rst)
        line_start |=> !line_start)
        else note_failure("line_start longer than one clock");

    vrender_next: assert property (@(posedge clk) disable iff (rst)
        int'(vrender) == (int'(vdump) + 1) % V_TOTAL)
        else note_failure("vrender is not the next line");

    // Pulse comes one clock after line_start of the programmed line
    raster_on_line: assert property (@(posedge clk) disable iff (rst)
        raster |-> ($past(line_start) && int'(vdump) == RASTER_LINE))
        else note_failure("raster pulse off its line");

    rgb_blanked: assert property (@(posedge clk) disable iff (rst)
        (!lhbl_dly || !lvbl_dly) |-> (red == '0 && green == '0 && blue == '0))
        else note_failure("RGB not zero during blanking");

endmodule

bind cps_video cps_video_props #(
    .H_ACTIVE (H_ACTIVE), .HS_START (HS_START), .HS_LEN (HS_LEN), .V_TOTAL (V_TOTAL),
    .V_ACTIVE (V_ACTIVE), .VS_START (VS_START), .VS_LEN (VS_LEN)
) u_props (
    .clk (clk), .rst (rst), .hdump (hdump), .vdump (vdump), .vrender (vrender),
    .hb (HB), .vb (VB), .hs (HS), .vs (VS), .line_start (line_start), .raster (raster),
    .lhbl_dly (LHBL_dly), .lvbl_dly (LVBL_dly), .red (red), .green (green), .blue (blue)
);

`default_nettype wire

//--- verif/cps_video_tb.sv
/* Testbench for cps_video on a 32x16 frame with pxl_cen on every other clock.
   Value checks are immediate assertions; timing checks live in the bound cps_video_props. */
`default_nettype none

module cps_video_tb;
    timeunit 1ns;
    timeprecision 1ns;
    import ppu_pkg::*;
    import video_timing_pkg::*;

    localparam int CLK_NS     = 100;
    localparam int H_TOTAL    = 32;
    localparam int H_ACTIVE   = 20;
    localparam int V_TOTAL    = 16;
    localparam int V_ACTIVE   = 10;
    localparam int FRAME_CLKS = H_TOTAL * V_TOTAL * 2;
    // Frames per test: timing 2, registers 1, raster 3, mixing 7, blanking 2
    localparam int TEST_FRAMES = 2 + 1 + 3 + 7 + 2;

    logic        clk = 1'b0;
    logic        rst, pxl_cen;
    cpu_bus_t    cpu;
    layer_pxl_t  obj_pxl, scr1_pxl, scr2_pxl, scr3_pxl;
    logic [15:0] mmr_dout;
    logic        raster, line_start, hs, vs, hb, vb, lhbl_dly, lvbl_dly;
    hpos_t       hdump;
    vpos_t       vdump, vrender;
    color_t      red, green, blue;

    int          seed = 607;
    int          test_errs, tests_passed, tests_failed;
    logic [15:0] ctrl_m, raster_m;
    pal_word_t   pal_m [2048];

    cps_video #(
        .H_TOTAL (H_TOTAL), .H_ACTIVE (H_ACTIVE), .HS_START (22), .HS_LEN (4),
        .V_TOTAL (V_TOTAL), .V_ACTIVE (V_ACTIVE), .VS_START (12), .VS_LEN (2)
    ) u_dut (
        .clk, .rst, .pxl_cen, .cpu, .obj_pxl, .scr1_pxl, .scr2_pxl, .scr3_pxl, .mmr_dout,
        .raster, .line_start, .hdump, .vdump, .vrender, .HS (hs), .VS (vs), .HB (hb),
        .VB (vb), .LHBL_dly (lhbl_dly), .LVBL_dly (lvbl_dly), .red, .green, .blue
    );

    always #(CLK_NS / 2) clk = ~clk;

    // Pixel enable on every other clock
    always @(negedge clk) pxl_cen <= ~pxl_cen;

    task automatic expect_eq(input string name, input logic [15:0] exp, input logic [15:0] got);
        assert (got === exp)
        else begin
            $display("Mismatch %s: expected %h, actual %h", name, exp, got);
            test_errs++;
        end
    endtask

    task automatic end_test(input string name);
        if (test_errs == 0) begin
            tests_passed++;
            $display("PASS %s", name);
        end else begin
            tests_failed++;
            $display("FAIL %s with %0d errors", name, test_errs);
        end
        test_errs = 0;
    endtask

    // Returns on the falling edge after the n-th pixel enable
    task automatic step_pixels(input int n);
        int k;
        k = 0;
        while (k < n) begin
            @(posedge clk);
            if (pxl_cen) begin
                k++;
            end
        end
        @(negedge clk);
    endtask

    task automatic cpu_write(input logic to_regs, input cpu_addr_t addr, input logic [1:0] dsn,
                             input logic [15:0] data);
        cpu = '{regs_cs: to_regs, pal_cs: !to_regs, addr: addr, dsn: dsn, dout: data};
        @(negedge clk);
        cpu.regs_cs = 1'b0;
        cpu.pal_cs  = 1'b0;
    endtask

    task automatic check_reg(input string name, input cpu_addr_t addr, input logic [15:0] exp);
        cpu.addr = addr;
        @(negedge clk);
        expect_eq(name, exp, mmr_dout);
    endtask

    // A high dsn bit keeps the old byte
    function automatic logic [15:0] merge_lanes(input logic [15:0] old, input logic [15:0] din,
                                                input logic [1:0] dsn);
        return {dsn[1] ? old[15:8] : din[15:8], dsn[0] ? old[7:0] : din[7:0]};
    endfunction

    // Back to front, so the front-most qualifying slot is the one kept
    function automatic pal_index_t mixed_index(input logic [15:0] ctrl,
                                               input layer_pxl_t [3:0] px);
        pal_index_t idx;
        layer_id_t  id;
        logic [3:0] en;
        idx = '1;
        en  = ctrl[11:8];
        for (int s = 3; s >= 0; s--) begin
            id = layer_id_t'(ctrl >> (2 * s));
            if (en[id] && px[id].color != 4'hF) begin
                idx = {id, px[id].pal, px[id].color};
            end
        end
        return idx;
    endfunction

    function automatic color_t channel(input pal_word_t w, input int lsb);
        logic [3:0] nib;
        nib = 4'(w >> lsb);
        return color_t'(nib) * (color_t'(w[15:12]) + 8'd1);
    endfunction

    function automatic layer_pxl_t rand_pxl();
        layer_pxl_t p;
        p.pal   = pal_sel_t'($random(seed));
        p.color = color_idx_t'({$random(seed)} % 15);
        return p;
    endfunction

    task automatic run_timing();
        int starts;
        starts = 0;
        repeat (2 * FRAME_CLKS) begin
            @(negedge clk);
            if (line_start) begin
                starts++;
            end
        end
        expect_eq("timing.line_starts", 16'(2 * V_TOTAL), 16'(starts));
    endtask

    task automatic run_regs();
        logic [1:0]  dsn;
        logic [15:0] data;
        cpu_addr_t   addr;
        check_reg("regs.ctrl_reset", REG_LAYER_CTRL, LAYER_CTRL_RST);
        check_reg("regs.raster_reset", REG_RASTER, 16'h0000);
        for (int i = 0; i < 12; i++) begin
            addr = cpu_addr_t'(i % 2);
            dsn  = 2'(i % 3);
            data = 16'($random(seed));
            if (addr == REG_RASTER) begin
                // Raster interrupt stays off until its own test
                data[15] = 1'b0;
                raster_m = merge_lanes(raster_m, data, dsn);
            end else begin
                ctrl_m = merge_lanes(ctrl_m, data, dsn);
            end
            cpu_write(1'b1, addr, dsn, data);
            check_reg("regs.readback", addr, (addr == REG_RASTER) ? raster_m : ctrl_m);
        end
        addr = cpu_addr_t'(2 + {$random(seed)} % 2046);
        cpu_write(1'b1, addr, 2'b00, 16'hFFFF);
        check_reg("regs.unmapped", addr, 16'h0000);
        check_reg("regs.ctrl_kept", REG_LAYER_CTRL, ctrl_m);
        check_reg("regs.raster_kept", REG_RASTER, raster_m);
    endtask

    task automatic count_raster(input int clocks, output int pulses);
        pulses = 0;
        repeat (clocks) begin
            @(negedge clk);
            if (raster) begin
                pulses++;
            end
        end
    endtask

    task automatic run_raster();
        int pulses;
        cpu_write(1'b1, REG_RASTER, 2'b00, 16'h8005);
        count_raster(2 * FRAME_CLKS, pulses);
        expect_eq("raster.enabled", 16'd2, 16'(pulses));
        cpu_write(1'b1, REG_RASTER, 2'b00, 16'h0005);
        count_raster(FRAME_CLKS, pulses);
        expect_eq("raster.disabled", 16'd0, 16'(pulses));
    endtask

    task automatic mix_case(input string name, input logic [15:0] ctrl,
                            input layer_pxl_t [3:0] px);
        pal_word_t w;
        cpu_write(1'b1, REG_LAYER_CTRL, 2'b00, ctrl);
        // Early in an active line, so the pixel reaches RGB well before HB
        while (!(hdump == 9'd1 && int'(vdump) < V_ACTIVE)) begin
            @(negedge clk);
        end
        obj_pxl  = px[LAYER_OBJ];
        scr1_pxl = px[LAYER_SCR1];
        scr2_pxl = px[LAYER_SCR2];
        scr3_pxl = px[LAYER_SCR3];
        step_pixels(5);
        w = pal_m[mixed_index(ctrl, px)];
        expect_eq({name, ".red"}, 16'(channel(w, 8)), 16'(red));
        expect_eq({name, ".green"}, 16'(channel(w, 4)), 16'(green));
        expect_eq({name, ".blue"}, 16'(channel(w, 0)), 16'(blue));
    endtask

    task automatic run_mix();
        layer_pxl_t [3:0] px;
        for (int a = 0; a < 2048; a++) begin
            pal_m[a] = 16'($random(seed));
            cpu_write(1'b0, cpu_addr_t'(a), 2'b00, pal_m[a]);
        end
        for (int l = 0; l < 4; l++) begin
            px[l] = rand_pxl();
        end
        mix_case("mix.default", LAYER_CTRL_RST, px);
        // Slots scr2, scr3, scr1, obj
        mix_case("mix.reorder", 16'h0F1E, px);
        mix_case("mix.disabled", 16'h0B1E, px);
        px[LAYER_SCR2].color = 4'hF;
        mix_case("mix.transparent", 16'h0F1E, px);
        for (int l = 0; l < 4; l++) begin
            px[l].color = 4'hF;
        end
        mix_case("mix.backdrop", LAYER_CTRL_RST, px);
    endtask

    // Delayed blanking must drop within four pixel enables of HB or VB rising
    task automatic check_blank_delay(input logic vertical);
        logic prev, cur, dly;
        int   waited;
        prev = 1'b1;
        cur  = vertical ? vb : hb;
        while (!(cur && !prev)) begin
            prev = cur;
            @(negedge clk);
            cur = vertical ? vb : hb;
        end
        waited = 0;
        dly    = vertical ? lvbl_dly : lhbl_dly;
        while (dly && waited < 4) begin
            step_pixels(1);
            waited++;
            dly = vertical ? lvbl_dly : lhbl_dly;
        end
        assert (!dly)
        else begin
            $display("%s stayed high for more than four pixel enables after %s rose",
                     vertical ? "LVBL_dly" : "LHBL_dly", vertical ? "VB" : "HB");
            test_errs++;
        end
    endtask

    task automatic run_blank();
        check_blank_delay(1'b0);
        check_blank_delay(1'b1);
    endtask

    initial begin
        rst          = 1'b1;
        pxl_cen      = 1'b0;
        cpu          = '0;
        obj_pxl      = '1;
        scr1_pxl     = '1;
        scr2_pxl     = '1;
        scr3_pxl     = '1;
        test_errs    = 0;
        tests_passed = 0;
        tests_failed = 0;
        ctrl_m       = LAYER_CTRL_RST;
        raster_m     = '0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        run_timing();
        end_test("timing");
        run_regs();
        end_test("registers");
        run_raster();
        end_test("raster");
        run_mix();
        end_test("mixing");
        run_blank();
        end_test("blanking");
        $display("Tests: %0d passed, %0d failed, %0d property failures",
                 tests_passed, tests_failed, u_dut.u_props.fail_count);
        if (tests_failed == 0 && u_dut.u_props.fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Watchdog, twice the frame budget of all tests
    initial begin
        #(TEST_FRAMES * FRAME_CLKS * CLK_NS * 2);
        $display("Timeout: tests still running after %0d frames", TEST_FRAMES * 2);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/cps_video.sv
/* Video output stage: timing, registers, layer mixer and palette.
   Layer pixels reach RGB three pxl_cen later, aligned with LHBL_dly and LVBL_dly. */
`default_nettype none

module cps_video #(
    parameter int H_TOTAL  = 512,
    parameter int H_ACTIVE = 384,
    parameter int HS_START = 400,
    parameter int HS_LEN   = 36,
    parameter int V_TOTAL  = 262,
    parameter int V_ACTIVE = 224,
    parameter int VS_START = 236,
    parameter int VS_LEN   = 3
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pxl_cen,
    input  ppu_pkg::cpu_bus_t       cpu,
    input  ppu_pkg::layer_pxl_t     obj_pxl,
    input  ppu_pkg::layer_pxl_t     scr1_pxl,
    input  ppu_pkg::layer_pxl_t     scr2_pxl,
    input  ppu_pkg::layer_pxl_t     scr3_pxl,
    output logic [15:0]             mmr_dout,
    output logic                    raster,
    output logic                    line_start,
    output video_timing_pkg::hpos_t hdump,
    output video_timing_pkg::vpos_t vdump,
    output video_timing_pkg::vpos_t vrender,
    output logic                    HS,
    output logic                    VS,
    output logic                    HB,
    output logic                    VB,
    output logic                    LHBL_dly,
    output logic                    LVBL_dly,
    output ppu_pkg::color_t         red,
    output ppu_pkg::color_t         green,
    output ppu_pkg::color_t         blue
);
    import ppu_pkg::*;
    import video_timing_pkg::*;

    blank_t      blank, mix_blank;
    sync_t       sync;
    logic [15:0] layer_ctrl;
    pal_index_t  pix_idx;

    assign HB = blank.hb;
    assign VB = blank.vb;
    assign HS = sync.hs;
    assign VS = sync.vs;

    video_timing #(
        .H_TOTAL  ( H_TOTAL  ), .H_ACTIVE ( H_ACTIVE ),
        .HS_START ( HS_START ), .HS_LEN   ( HS_LEN   ),
        .V_TOTAL  ( V_TOTAL  ), .V_ACTIVE ( V_ACTIVE ),
        .VS_START ( VS_START ), .VS_LEN   ( VS_LEN   )
    ) u_timing (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .pxl_cen    ( pxl_cen    ),
        .hdump      ( hdump      ),
        .vdump      ( vdump      ),
        .vrender    ( vrender    ),
        .blank      ( blank      ),
        .sync       ( sync       ),
        .line_start ( line_start )
    );

    ppu_regs u_regs (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .cpu        ( cpu        ),
        .line_start ( line_start ),
        .vdump      ( vdump      ),
        .mmr_dout   ( mmr_dout   ),
        .layer_ctrl ( layer_ctrl ),
        .raster     ( raster     )
    );

    layer_mix u_mix (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .pxl_cen    ( pxl_cen    ),
        .layer_ctrl ( layer_ctrl ),
        .obj_pxl    ( obj_pxl    ),
        .scr1_pxl   ( scr1_pxl   ),
        .scr2_pxl   ( scr2_pxl   ),
        .scr3_pxl   ( scr3_pxl   ),
        .blank_in   ( blank      ),
        .pix_idx    ( pix_idx    ),
        .blank_out  ( mix_blank  )
    );

    palette u_pal (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .pxl_cen    ( pxl_cen    ),
        .cpu        ( cpu        ),
        .pix_idx    ( pix_idx    ),
        .blank_in   ( mix_blank  ),
        .red        ( red        ),
        .green      ( green      ),
        .blue       ( blue       ),
        .lhbl_dly   ( LHBL_dly   ),
        .lvbl_dly   ( LVBL_dly   )
    );

endmodule

`default_nettype wire

//--- verilog/layer_mix.sv
/* Priority mixer with one pxl_cen of latency. Slot 0 of layer_ctrl is front-most;
   when nothing is visible the backdrop index comes out. */
`default_nettype none

module layer_mix (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     pxl_cen,
    input  logic [15:0]              layer_ctrl,
    input  ppu_pkg::layer_pxl_t      obj_pxl,
    input  ppu_pkg::layer_pxl_t      scr1_pxl,
    input  ppu_pkg::layer_pxl_t      scr2_pxl,
    input  ppu_pkg::layer_pxl_t      scr3_pxl,
    input  video_timing_pkg::blank_t blank_in,
    output ppu_pkg::pal_index_t      pix_idx,
    output video_timing_pkg::blank_t blank_out
);
    import ppu_pkg::*;

    layer_pxl_t by_id [4];
    pal_index_t pick;

    // Layers indexed by their code so a slot can select them directly
    assign by_id[LAYER_OBJ]  = obj_pxl;
    assign by_id[LAYER_SCR1] = scr1_pxl;
    assign by_id[LAYER_SCR2] = scr2_pxl;
    assign by_id[LAYER_SCR3] = scr3_pxl;

    always_comb begin
        layer_id_t  id;
        layer_pxl_t cand;
        logic       found;
        pick  = BACKDROP_IDX;
        found = 1'b0;
        for (int s = 0; s < 4; s++) begin
            id   = layer_id_t'(layer_ctrl[2*s +: 2]);
            cand = by_id[id];
            // First enabled, non-transparent slot wins
            if (!found && layer_ctrl[8 + id] && (cand.color != TRANSP_COLOR)) begin
                pick  = {id, cand.pal, cand.color};
                found = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            pix_idx <= pick;
        end
    end

    // Blanking travels with the index, starts out blanked
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            blank_out <= '1;
        end else if (pxl_cen) begin
            blank_out <= blank_in;
        end
    end

endmodule

`default_nettype wire

//--- verilog/palette.sv
/* 2048-word palette RAM and color conversion, two pxl_cen of latency.
   Channels are nibble times (brightness + 1) and forced to zero while blanked. */
`default_nettype none

module palette (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     pxl_cen,
    input  ppu_pkg::cpu_bus_t        cpu,
    input  ppu_pkg::pal_index_t      pix_idx,
    input  video_timing_pkg::blank_t blank_in,
    output ppu_pkg::color_t          red,
    output ppu_pkg::color_t          green,
    output ppu_pkg::color_t          blue,
    output logic                     lhbl_dly,
    output logic                     lvbl_dly
);
    import ppu_pkg::*;
    import video_timing_pkg::*;

    pal_word_t pal_ram [2048];
    pal_word_t pal_q;
    blank_t    blank_d1;

    function automatic color_t scale(input logic [3:0] nib, input logic [3:0] bri);
        scale = {4'd0, nib} * ({4'd0, bri} + 8'd1);
    endfunction

    // Byte-lane CPU writes, upper lane holds brightness and red
    always_ff @(posedge clk) begin
        if (cpu.pal_cs && !cpu.dsn[1]) begin
            pal_ram[cpu.addr][15:8] <= cpu.dout[15:8];
        end
        if (cpu.pal_cs && !cpu.dsn[0]) begin
            pal_ram[cpu.addr][7:0] <= cpu.dout[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            pal_q <= pal_ram[pix_idx];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            blank_d1 <= '1;
            lhbl_dly <= 1'b0;
            lvbl_dly <= 1'b0;
            red      <= '0;
            green    <= '0;
            blue     <= '0;
        end else if (pxl_cen) begin
            blank_d1 <= blank_in;
            lhbl_dly <= ~blank_d1.hb;
            lvbl_dly <= ~blank_d1.vb;
            if (blank_d1.hb || blank_d1.vb) begin
                red   <= '0;
                green <= '0;
                blue  <= '0;
            end else begin
                red   <= scale(pal_q[11:8], pal_q[15:12]);
                green <= scale(pal_q[7:4], pal_q[15:12]);
                blue  <= scale(pal_q[3:0], pal_q[15:12]);
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/ppu_pkg.sv
/* Pixel, palette and CPU bus types for the video output stage.
   A color index of all ones is transparent; palette index all ones is the backdrop. */
`default_nettype none

package ppu_pkg;

    typedef logic [3:0]  color_idx_t;
    typedef logic [4:0]  pal_sel_t;
    typedef logic [1:0]  layer_id_t;
    typedef logic [10:0] pal_index_t;
    typedef logic [15:0] pal_word_t;
    typedef logic [7:0]  color_t;
    typedef logic [10:0] cpu_addr_t;

    // One layer pixel as delivered by a tile or sprite engine
    typedef struct packed {
        pal_sel_t   pal;
        color_idx_t color;
    } layer_pxl_t;

    // CPU access, one-clock strobes
    typedef struct packed {
        logic        regs_cs;
        logic        pal_cs;
        cpu_addr_t   addr;
        logic [1:0]  dsn;
        logic [15:0] dout;
    } cpu_bus_t;

    // Layer codes, also the top bits of the palette index
    localparam layer_id_t LAYER_OBJ  = 2'd0;
    localparam layer_id_t LAYER_SCR1 = 2'd1;
    localparam layer_id_t LAYER_SCR2 = 2'd2;
    localparam layer_id_t LAYER_SCR3 = 2'd3;

    localparam color_idx_t TRANSP_COLOR = '1;
    localparam pal_index_t BACKDROP_IDX = '1;

    // Register word addresses
    localparam cpu_addr_t REG_LAYER_CTRL = 11'd0;
    localparam cpu_addr_t REG_RASTER     = 11'd1;

    // Order obj, scr1, scr2, scr3 with every layer enabled
    localparam logic [15:0] LAYER_CTRL_RST = 16'h0FE4;

endpackage

`default_nettype wire

//--- verilog/ppu_regs.sv
/* Layer control and raster registers with byte-lane writes and live readback.
   Only word addresses 0 and 1 are mapped; the rest read as zero. */
`default_nettype none

module ppu_regs (
    input  logic                    clk,
    input  logic                    rst,
    input  ppu_pkg::cpu_bus_t       cpu,
    input  logic                    line_start,
    input  video_timing_pkg::vpos_t vdump,
    output logic [15:0]             mmr_dout,
    output logic [15:0]             layer_ctrl,
    output logic                    raster
);
    import ppu_pkg::*;
    import video_timing_pkg::*;

    logic [15:0] raster_reg;
    vpos_t       raster_line;
    logic        raster_en;

    // Merge the enabled byte lanes of a write into a register
    function automatic logic [15:0] lane_write(
        input logic [15:0] cur,
        input logic [15:0] din,
        input logic [1:0]  dsn
    );
        lane_write = cur;
        if (!dsn[1]) begin
            lane_write[15:8] = din[15:8];
        end
        if (!dsn[0]) begin
            lane_write[7:0] = din[7:0];
        end
    endfunction

    assign raster_line = raster_reg[8:0];
    assign raster_en   = raster_reg[15];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            layer_ctrl <= LAYER_CTRL_RST;
            raster_reg <= '0;
            raster     <= 1'b0;
        end else begin
            if (cpu.regs_cs) begin
                case (cpu.addr)
                    REG_LAYER_CTRL: begin
                        layer_ctrl <= lane_write(layer_ctrl, cpu.dout, cpu.dsn);
                    end
                    REG_RASTER: begin
                        raster_reg <= lane_write(raster_reg, cpu.dout, cpu.dsn);
                    end
                    default: begin
                    end
                endcase
            end
            // vdump already holds the new line when line_start is seen
            raster <= line_start && raster_en && (vdump == raster_line);
        end
    end

    // Readback follows the address with no wait state
    always_comb begin
        case (cpu.addr)
            REG_LAYER_CTRL: mmr_dout = layer_ctrl;
            REG_RASTER:     mmr_dout = raster_reg;
            default:        mmr_dout = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/video_timing.sv
/* Pixel and line counters advancing on pxl_cen. Sync windows must lie inside the totals,
   and blanking, sync and line_start come out registered. */
`default_nettype none

module video_timing #(
    parameter int H_TOTAL  = 512,
    parameter int H_ACTIVE = 384,
    parameter int HS_START = 400,
    parameter int HS_LEN   = 36,
    parameter int V_TOTAL  = 262,
    parameter int V_ACTIVE = 224,
    parameter int VS_START = 236,
    parameter int VS_LEN   = 3
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     pxl_cen,
    output video_timing_pkg::hpos_t  hdump,
    output video_timing_pkg::vpos_t  vdump,
    output video_timing_pkg::vpos_t  vrender,
    output video_timing_pkg::blank_t blank,
    output video_timing_pkg::sync_t  sync,
    output logic                     line_start
);
    import video_timing_pkg::*;

    localparam hpos_t H_LAST   = hpos_t'(H_TOTAL - 1);
    localparam hpos_t H_ACT    = hpos_t'(H_ACTIVE);
    localparam hpos_t HS_BEGIN = hpos_t'(HS_START);
    localparam hpos_t HS_END   = hpos_t'(HS_START + HS_LEN);
    localparam vpos_t V_LAST   = vpos_t'(V_TOTAL - 1);
    localparam vpos_t V_ACT    = vpos_t'(V_ACTIVE);
    localparam vpos_t VS_BEGIN = vpos_t'(VS_START);
    localparam vpos_t VS_END   = vpos_t'(VS_START + VS_LEN);

    hpos_t h_next;
    vpos_t v_next;

    // Next position, the line only moves when the pixel counter wraps
    always_comb begin
        v_next = vdump;
        if (hdump == H_LAST) begin
            h_next = '0;
            v_next = (vdump == V_LAST) ? '0 : vdump + 1'b1;
        end else begin
            h_next = hdump + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hdump      <= '0;
            vdump      <= '0;
            blank      <= '0;
            sync       <= '0;
            line_start <= 1'b0;
        end else begin
            line_start <= 1'b0;
            if (pxl_cen) begin
                hdump      <= h_next;
                vdump      <= v_next;
                // Decoded from the new count so they line up with hdump/vdump
                blank.hb   <= h_next >= H_ACT;
                blank.vb   <= v_next >= V_ACT;
                sync.hs    <= (h_next >= HS_BEGIN) && (h_next < HS_END);
                sync.vs    <= (v_next >= VS_BEGIN) && (v_next < VS_END);
                line_start <= h_next == '0;
            end
        end
    end

    // Line being prepared by the layer engines
    assign vrender = (vdump == V_LAST) ? '0 : vdump + 1'b1;

endmodule

`default_nettype wire

//--- verilog/video_timing_pkg.sv
/* Screen position and sync types shared by the timing generator and the pixel pipeline.
   Positions are 9 bits wide, so H_TOTAL and V_TOTAL must not exceed 512. */
`default_nettype none

package video_timing_pkg;

    // Horizontal pixel position within a line
    typedef logic [8:0] hpos_t;

    // Line number within a frame
    typedef logic [8:0] vpos_t;

    // High while the beam is outside the active area
    typedef struct packed {
        logic hb;
        logic vb;
    } blank_t;

    // Sync pulses, active high
    typedef struct packed {
        logic hs;
        logic vs;
    } sync_t;

endpackage

`default_nettype wire
